// ==== design/ring_router_consts.svh ====
`ifndef RING_ROUTER_CONSTS_SVH
`define RING_ROUTER_CONSTS_SVH

// ----------------------------------------
// Packet field widths
// ----------------------------------------
`define RR_PKT_W 64                    // Full packet
`define RR_HOP_W 8                     // Hop count field
`define RR_SRC_W 16                    // Source id, carried unchanged
`define RR_PAY_W 32                    // Payload

// Whatever is left over after vc, dir and the fields above
`define RR_RSV_W (`RR_PKT_W - 2 - `RR_HOP_W - `RR_SRC_W - `RR_PAY_W)

// Hop bit that decides stay-on-ring vs exit to pe
`define RR_ROUTE_BIT 0

// ----------------------------------------
// Legal hop codes on pe injection
// ----------------------------------------
`define RR_HOP_1 8'h01                 // One hop, pass as is
`define RR_HOP_2 8'h03                 // Two hops, forced cw
`define RR_HOP_3 8'h07                 // Three hops, turned around to one hop

`endif

// ==== design/ring_pkt_pkg.sv ====
`include "ring_router_consts.svh"

package ring_pkt_pkg;

    // Ring direction, one bit in the packet
    typedef enum logic {
        DIR_CW  = 1'b0,
        DIR_CCW = 1'b1
    } ring_dir_e;

    // Packet layout, msb first
    typedef struct packed {
        logic                  vc;        // Virtual channel tag
        ring_dir_e             dir;       // Travel direction
        logic [`RR_RSV_W-1:0]  rsv;       // Unused
        logic [`RR_HOP_W-1:0]  hop;       // Shifted right on every forward
        logic [`RR_SRC_W-1:0]  src;       // Source node
        logic [`RR_PAY_W-1:0]  payload;
    } ring_pkt_t;

endpackage

// ==== design/ring_ctl_pkg.sv ====
package ring_ctl_pkg;

    // One link in either direction: strobe plus packet
    // Receiver answers with a separate ready line
    typedef struct packed {
        logic                    send;    // Packet valid this cycle
        ring_pkt_pkg::ring_pkt_t pkt;
    } ring_link_t;

    // Router ports, also used as slot index inside a plane
    typedef enum logic [1:0] {
        PORT_CW  = 2'd0,
        PORT_CCW = 2'd1,
        PORT_PE  = 2'd2
    } port_e;

    // Which requester won the last grant
    typedef enum logic {
        LAST_A = 1'b0,
        LAST_B = 1'b1
    } arb_state_e;

endpackage

// ==== design/slot_buffer.sv ====
`timescale 1ns/1ps

module slot_buffer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wen,      // Load d_in, never issued while full
    input  logic                    ren,      // Consume the held packet
    input  ring_pkt_pkg::ring_pkt_t d_in,
    output logic                    full,
    output ring_pkt_pkg::ring_pkt_t d_out
);

    // ----------------------------------------
    // Occupancy flag
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (wen) begin
            full <= 1'b1;
        end else if (ren) begin
            full <= 1'b0;                     // Drained this edge
        end
    end

    // Data register, only valid while full
    always_ff @(posedge clk) begin
        if (wen) begin
            d_out <= d_in;
        end
    end

endmodule

// ==== design/inject_filter.sv ====
`timescale 1ns/1ps
`include "ring_router_consts.svh"

module inject_filter (
    input  ring_pkt_pkg::ring_pkt_t pkt_in,   // Raw packet from the pe
    output ring_pkt_pkg::ring_pkt_t pkt_out,  // Rewritten packet
    output logic                    drop      // Bad hop code, discard
);
    import ring_pkt_pkg::*;

    // ----------------------------------------
    // Hop code check and rewrite
    // ----------------------------------------
    always_comb begin
        pkt_out = pkt_in;
        drop    = 1'b0;
        case (pkt_in.hop)
            `RR_HOP_1: begin
                pkt_out = pkt_in;             // Next node is the target
            end
            `RR_HOP_2: begin
                pkt_out.dir = DIR_CW;         // Two hops always go cw
            end
            `RR_HOP_3: begin
                // Shorter the other way round, one hop back
                if (pkt_in.dir == DIR_CW) begin
                    pkt_out.dir = DIR_CCW;
                end else begin
                    pkt_out.dir = DIR_CW;
                end
                pkt_out.hop = `RR_HOP_1;
            end
            default: begin
                drop = 1'b1;                  // Faulty hop count
            end
        endcase
    end

endmodule

// ==== design/rr_arbiter.sv ====
`timescale 1ns/1ps

module rr_arbiter (
    input  logic clk,
    input  logic rst_n,
    input  logic req_a,
    input  logic req_b,
    output logic gnt_a,
    output logic gnt_b
);
    import ring_ctl_pkg::*;

    arb_state_e last_q;                       // Winner of the previous grant

    // Grant logic, tie goes to whoever lost last time
    always_comb begin
        gnt_a = req_a;
        gnt_b = req_b;
        if (req_a && req_b) begin
            gnt_a = (last_q == LAST_B);
            gnt_b = (last_q == LAST_A);
        end
    end

    // History update on any grant
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_q <= LAST_B;                 // a wins the first tie
        end else if (gnt_a) begin
            last_q <= LAST_A;
        end else if (gnt_b) begin
            last_q <= LAST_B;
        end
    end

endmodule

// ==== design/vc_plane.sv ====
`timescale 1ns/1ps
`include "ring_router_consts.svh"

module vc_plane (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     active,        // Accept/drain phase, else forward
    input  ring_ctl_pkg::ring_link_t cw_in,
    input  ring_ctl_pkg::ring_link_t ccw_in,
    input  ring_ctl_pkg::ring_link_t pe_in,
    input  logic                     cw_ready_out,
    input  logic                     ccw_ready_out,
    input  logic                     pe_ready_out,
    output logic                     cw_ready_in,
    output logic                     ccw_ready_in,
    output logic                     pe_ready_in,
    output ring_ctl_pkg::ring_link_t cw_out,
    output ring_ctl_pkg::ring_link_t ccw_out,
    output ring_ctl_pkg::ring_link_t pe_out
);
    import ring_pkt_pkg::*;
    import ring_ctl_pkg::*;

    // Slot control, bit index is port_e
    logic [2:0] in_wen, in_ren, in_full, in_send, in_keep;
    logic [2:0] out_wen, out_ren, out_full, ready_out;
    ring_pkt_t  in_d  [3];
    ring_pkt_t  in_q  [3];
    ring_pkt_t  out_d [3];
    ring_pkt_t  out_q [3];

    ring_pkt_t pe_filt;                        // pe packet after hop rewrite
    logic      pe_drop;
    logic      fwd;                            // Forwarding phase

    // Requests and grants, named src_to_dst
    logic cw_to_cw, cw_to_pe, ccw_to_ccw, ccw_to_pe, pe_to_cw, pe_to_ccw;
    logic g_cw_cw, g_cw_pe, g_ccw_ccw, g_ccw_pe, g_pe_cw, g_pe_ccw;

    // Every forward consumes one hop
    function automatic ring_pkt_t hop_shift(input ring_pkt_t p);
        ring_pkt_t r;
        r     = p;
        r.hop = p.hop >> 1;
        return r;
    endfunction

    // ----------------------------------------
    // Input side
    // ----------------------------------------
    inject_filter u_filter (.pkt_in(pe_in.pkt), .pkt_out(pe_filt), .drop(pe_drop));

    assign in_send   = {pe_in.send, ccw_in.send, cw_in.send};
    assign in_keep   = {~pe_drop, 2'b11};      // Only pe packets can be dropped
    assign ready_out = {pe_ready_out, ccw_ready_out, cw_ready_out};
    assign in_d[PORT_CW]  = cw_in.pkt;
    assign in_d[PORT_CCW] = ccw_in.pkt;
    assign in_d[PORT_PE]  = pe_filt;
    assign fwd = ~active;

    for (genvar g = 0; g < 3; g++) begin : g_port
        assign in_wen[g]  = active && in_send[g] && !in_full[g] && in_keep[g];
        assign out_ren[g] = active && out_full[g] && ready_out[g];   // Handshake done

        slot_buffer u_in (.clk(clk), .rst_n(rst_n), .wen(in_wen[g]), .ren(in_ren[g]),
                          .d_in(in_d[g]), .full(in_full[g]), .d_out(in_q[g]));
        slot_buffer u_out (.clk(clk), .rst_n(rst_n), .wen(out_wen[g]), .ren(out_ren[g]),
                           .d_in(out_d[g]), .full(out_full[g]), .d_out(out_q[g]));
    end

    // ----------------------------------------
    // Routing requests
    // ----------------------------------------
    // Transit keeps direction while hop bit 0 is set, else exits to pe
    assign cw_to_cw   = fwd && in_full[PORT_CW] && in_q[PORT_CW].hop[`RR_ROUTE_BIT]
                        && !out_full[PORT_CW];
    assign cw_to_pe   = fwd && in_full[PORT_CW] && !in_q[PORT_CW].hop[`RR_ROUTE_BIT]
                        && !out_full[PORT_PE];
    assign ccw_to_ccw = fwd && in_full[PORT_CCW] && in_q[PORT_CCW].hop[`RR_ROUTE_BIT]
                        && !out_full[PORT_CCW];
    assign ccw_to_pe  = fwd && in_full[PORT_CCW] && !in_q[PORT_CCW].hop[`RR_ROUTE_BIT]
                        && !out_full[PORT_PE];
    // Injected packets follow their dir bit
    assign pe_to_cw   = fwd && in_full[PORT_PE] && (in_q[PORT_PE].dir == DIR_CW)
                        && !out_full[PORT_CW];
    assign pe_to_ccw  = fwd && in_full[PORT_PE] && (in_q[PORT_PE].dir == DIR_CCW)
                        && !out_full[PORT_CCW];

    // One arbiter per output slot
    rr_arbiter u_arb_cw (.clk(clk), .rst_n(rst_n), .req_a(cw_to_cw), .req_b(pe_to_cw),
                         .gnt_a(g_cw_cw), .gnt_b(g_pe_cw));
    rr_arbiter u_arb_ccw (.clk(clk), .rst_n(rst_n), .req_a(ccw_to_ccw), .req_b(pe_to_ccw),
                          .gnt_a(g_ccw_ccw), .gnt_b(g_pe_ccw));
    rr_arbiter u_arb_pe (.clk(clk), .rst_n(rst_n), .req_a(cw_to_pe), .req_b(ccw_to_pe),
                         .gnt_a(g_cw_pe), .gnt_b(g_ccw_pe));

    // ----------------------------------------
    // Transfer on grant
    // ----------------------------------------
    assign in_ren[PORT_CW]  = g_cw_cw | g_cw_pe;
    assign in_ren[PORT_CCW] = g_ccw_ccw | g_ccw_pe;
    assign in_ren[PORT_PE]  = g_pe_cw | g_pe_ccw;
    assign out_wen[PORT_CW]  = g_cw_cw | g_pe_cw;
    assign out_wen[PORT_CCW] = g_ccw_ccw | g_pe_ccw;
    assign out_wen[PORT_PE]  = g_cw_pe | g_ccw_pe;
    assign out_d[PORT_CW]  = hop_shift(g_cw_cw ? in_q[PORT_CW] : in_q[PORT_PE]);
    assign out_d[PORT_CCW] = hop_shift(g_ccw_ccw ? in_q[PORT_CCW] : in_q[PORT_PE]);
    assign out_d[PORT_PE]  = hop_shift(g_cw_pe ? in_q[PORT_CW] : in_q[PORT_CCW]);

    // Port side, top picks the active plane
    assign cw_ready_in  = ~in_full[PORT_CW];
    assign ccw_ready_in = ~in_full[PORT_CCW];
    assign pe_ready_in  = ~in_full[PORT_PE];   // Drop does not touch ready
    assign cw_out  = '{send: out_full[PORT_CW], pkt: out_q[PORT_CW]};
    assign ccw_out = '{send: out_full[PORT_CCW], pkt: out_q[PORT_CCW]};
    assign pe_out  = '{send: out_full[PORT_PE], pkt: out_q[PORT_PE]};

endmodule

// ==== design/gold_router.sv ====
`timescale 1ns/1ps

module gold_router (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     polarity,      // 1: even plane on the ports
    input  ring_ctl_pkg::ring_link_t cw_in,
    input  ring_ctl_pkg::ring_link_t ccw_in,
    input  ring_ctl_pkg::ring_link_t pe_in,
    input  logic                     cw_ready_out,
    input  logic                     ccw_ready_out,
    input  logic                     pe_ready_out,
    output logic                     cw_ready_in,
    output logic                     ccw_ready_in,
    output logic                     pe_ready_in,
    output ring_ctl_pkg::ring_link_t cw_out,
    output ring_ctl_pkg::ring_link_t ccw_out,
    output ring_ctl_pkg::ring_link_t pe_out
);
    import ring_ctl_pkg::*;

    logic       even_active, odd_active;
    logic       even_cw_rdy, even_ccw_rdy, even_pe_rdy;
    logic       odd_cw_rdy, odd_ccw_rdy, odd_pe_rdy;
    ring_link_t even_cw_out, even_ccw_out, even_pe_out;
    ring_link_t odd_cw_out, odd_ccw_out, odd_pe_out;

    // ----------------------------------------
    // Phase split
    // ----------------------------------------
    assign even_active = polarity;
    assign odd_active  = ~polarity;            // Odd forwards while even is on the ports

    // Both planes see every input, only the active one latches it
    vc_plane even_plane (
        .clk(clk), .rst_n(rst_n), .active(even_active),
        .cw_in(cw_in), .ccw_in(ccw_in), .pe_in(pe_in),
        .cw_ready_out(cw_ready_out), .ccw_ready_out(ccw_ready_out),
        .pe_ready_out(pe_ready_out),
        .cw_ready_in(even_cw_rdy), .ccw_ready_in(even_ccw_rdy), .pe_ready_in(even_pe_rdy),
        .cw_out(even_cw_out), .ccw_out(even_ccw_out), .pe_out(even_pe_out)
    );

    vc_plane odd_plane (
        .clk(clk), .rst_n(rst_n), .active(odd_active),
        .cw_in(cw_in), .ccw_in(ccw_in), .pe_in(pe_in),
        .cw_ready_out(cw_ready_out), .ccw_ready_out(ccw_ready_out),
        .pe_ready_out(pe_ready_out),
        .cw_ready_in(odd_cw_rdy), .ccw_ready_in(odd_ccw_rdy), .pe_ready_in(odd_pe_rdy),
        .cw_out(odd_cw_out), .ccw_out(odd_ccw_out), .pe_out(odd_pe_out)
    );

    // ----------------------------------------
    // Port muxing
    // ----------------------------------------
    // Ready lines show the plane that accepts this cycle
    assign cw_ready_in  = even_active ? even_cw_rdy : odd_cw_rdy;
    assign ccw_ready_in = even_active ? even_ccw_rdy : odd_ccw_rdy;
    assign pe_ready_in  = even_active ? even_pe_rdy : odd_pe_rdy;

    // Outgoing links from the draining plane
    assign cw_out  = even_active ? even_cw_out : odd_cw_out;
    assign ccw_out = even_active ? even_ccw_out : odd_ccw_out;
    assign pe_out  = even_active ? even_pe_out : odd_pe_out;

endmodule

// ==== tests/gold_router_asserts.sv ====
`timescale 1ns/1ps

module gold_router_asserts (
    input logic                     clk,
    input logic                     rst_n,
    input ring_ctl_pkg::ring_link_t cw_out,
    input ring_ctl_pkg::ring_link_t ccw_out,
    input ring_ctl_pkg::ring_link_t pe_out,
    input logic [11:0]              wen,    // Write strobes of all twelve slots
    input logic [11:0]              full    // Same order as wen
);

    // Exits toward the pe carry no hops left
    pe_hop_zero: assert property (@(posedge clk) disable iff (!rst_n)
        pe_out.send |-> (pe_out.pkt.hop == '0))
        else $error("pe output sent a packet with hop %h", pe_out.pkt.hop);

    // Sampled mid-cycle, the first reset edge has emptied every slot by then
    quiet_in_reset: assert property (@(negedge clk)
        !rst_n |-> !(cw_out.send || ccw_out.send || pe_out.send))
        else $error("send line high while rst_n is low");

    // A slot holding a packet is never loaded again
    no_overwrite: assert property (@(posedge clk) disable iff (!rst_n)
        (wen & full) == '0)
        else $error("slot write while full, wen %h full %h", wen, full);

endmodule

bind gold_router gold_router_asserts u_asserts (
    .clk(clk), .rst_n(rst_n), .cw_out(cw_out), .ccw_out(ccw_out), .pe_out(pe_out),
    .wen({even_plane.in_wen, even_plane.out_wen, odd_plane.in_wen, odd_plane.out_wen}),
    .full({even_plane.in_full, even_plane.out_full, odd_plane.in_full, odd_plane.out_full})
);

// ==== tests/gold_router_tb.sv ====
`timescale 1ns/1ps

module gold_router_tb;
    import ring_pkt_pkg::*;
    import ring_ctl_pkg::*;

    localparam int RUN_CYCLES     = 600;                      // Rough length of all tests
    localparam int TIMEOUT_CYCLES = 3 * RUN_CYCLES + 200;     // 2000
    localparam int WAIT_LIMIT     = 100;                      // Per handshake or drain

    // One packet the scoreboard waits for
    typedef struct packed {
        port_e     port;                                      // Predicted exit port
        logic      ch;                                        // Plane, polarity at entry
        ring_pkt_t pkt;
    } exp_entry_t;

    logic       clk = 1'b0;
    logic       rst_n = 1'b0;
    logic       polarity = 1'b0;
    ring_link_t cw_in = '0, ccw_in = '0, pe_in = '0;
    logic       cw_ready_out = 1'b1, ccw_ready_out = 1'b1, pe_ready_out = 1'b1;
    logic       cw_ready_in, ccw_ready_in, pe_ready_in;
    ring_link_t cw_out, ccw_out, pe_out;
    exp_entry_t exp_q[$];
    string      cur_test;
    int         errors = 0, test_err0 = 0, tests_run = 0, tests_failed = 0;
    int         rx_count = 0, cycles = 0;

    gold_router dut (.*);

    always #5 clk = ~clk;

    // Channel phase flips every cycle
    always @(posedge clk) begin
        #1;
        polarity = ~polarity;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles, tests did not finish", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    function automatic ring_pkt_t mk_pkt(ring_dir_e d, logic [7:0] hop, logic [15:0] src);
        ring_pkt_t p;
        p = '{vc: 1'b0, dir: d, rsv: '0, hop: hop, src: src, payload: $urandom};
        return p;
    endfunction

    function automatic logic port_ready(port_e p);
        case (p)
            PORT_CW:  return cw_ready_in;
            PORT_CCW: return ccw_ready_in;
            default:  return pe_ready_in;
        endcase
    endfunction

    task automatic drive_link(port_e p, ring_link_t l);
        case (p)
            PORT_CW:  cw_in = l;
            PORT_CCW: ccw_in = l;
            default:  pe_in = l;
        endcase
    endtask

    // Exit port and packet by the routing rules, 0 when the packet is dropped
    function automatic logic predict(port_e p, ring_pkt_t pkt, output port_e op,
                                     output ring_pkt_t want);
        want = pkt;
        op   = pkt.hop[0] ? p : PORT_PE;                      // Transit keeps or exits
        if (p == PORT_PE) begin
            if (pkt.hop == 8'h03) begin
                want.dir = DIR_CW;
            end else if (pkt.hop == 8'h07) begin
                want.dir = ring_dir_e'(~pkt.dir);             // Turned around
                want.hop = 8'h01;
            end else if (pkt.hop != 8'h01) begin
                return 1'b0;
            end
            op = (want.dir == DIR_CW) ? PORT_CW : PORT_CCW;
        end
        want.hop = want.hop >> 1;                             // One forward
        return 1'b1;
    endfunction

    // Hold send until ready is seen, then log what should come out
    task automatic send_pkt(port_e p, ring_pkt_t pkt);
        exp_entry_t e;
        int         n;
        bit         acc;
        acc = 1'b0;
        drive_link(p, '{send: 1'b1, pkt: pkt});
        for (n = 0; n < WAIT_LIMIT && !acc; n++) begin
            @(negedge clk);
            acc  = port_ready(p);
            e.ch = polarity;                                  // Plane that takes it
            @(posedge clk);
            #1;
        end
        drive_link(p, '0);
        if (acc && predict(p, pkt, e.port, e.pkt)) exp_q.push_back(e);
        assert (acc) else begin
            $display("%s: %s input never became ready", cur_test, p.name());
            errors++;
        end
    endtask

    // ----------------------------------------
    // Output monitor and scoreboard
    // ----------------------------------------
    task automatic check_out(port_e p, ring_pkt_t pkt);
        int i;
        int idx;
        idx = -1;
        for (i = 0; i < exp_q.size() && idx < 0; i++) begin
            if (exp_q[i].port == p && exp_q[i].ch == polarity && exp_q[i].pkt.src == pkt.src)
                idx = i;                                      // Oldest from this source
        end
        rx_count++;
        assert (idx >= 0) else begin
            $display("%s: unexpected packet from src %h on %s output", cur_test, pkt.src,
                     p.name());
            errors++;
        end
        if (idx >= 0) begin
            assert (exp_q[idx].pkt == pkt) else begin
                $display("[ERROR] %s: expected %h, actual %h", cur_test, exp_q[idx].pkt, pkt);
                errors++;
            end
            exp_q.delete(idx);
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && cw_out.send && cw_ready_out) check_out(PORT_CW, cw_out.pkt);
        if (rst_n && ccw_out.send && ccw_ready_out) check_out(PORT_CCW, ccw_out.pkt);
        if (rst_n && pe_out.send && pe_ready_out) check_out(PORT_PE, pe_out.pkt);
    end

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        assert (exp_q.size() == 0) else begin
            $display("%s: %0d packets never delivered", cur_test, exp_q.size());
            errors++;
        end
        exp_q.delete();
    endtask

    task automatic start_test(string name);
        cur_test  = name;
        test_err0 = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_err0) begin
            $display("%-14s passed", cur_test);
        end else begin
            tests_failed++;
            $display("%-14s failed with %0d errors", cur_test, errors - test_err0);
        end
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic reset_test();
        logic [5:0] st;
        start_test("reset_state");
        repeat (2) begin                                      // Both planes on the ports
            @(negedge clk);
            st = {cw_ready_in, ccw_ready_in, pe_ready_in, cw_out.send, ccw_out.send,
                  pe_out.send};
            assert (st == 6'b111000) else begin
                $display("[ERROR] %s: expected 111000, actual %b", cur_test, st);
                errors++;
            end
        end
        @(posedge clk);
        #1;
        end_test();
    endtask

    task automatic inject_test();
        start_test("pe_inject");
        send_pkt(PORT_PE, mk_pkt(DIR_CW, 8'h01, 16'h0e01));
        send_pkt(PORT_PE, mk_pkt(DIR_CCW, 8'h01, 16'h0e02));
        send_pkt(PORT_PE, mk_pkt(DIR_CCW, 8'h03, 16'h0e03));   // Forced cw
        send_pkt(PORT_PE, mk_pkt(DIR_CW, 8'h07, 16'h0e04));    // Back ccw, one hop
        wait_drain();
        end_test();
    endtask

    task automatic drop_test();
        int n0;
        start_test("fault_drop");
        n0 = rx_count;
        send_pkt(PORT_PE, mk_pkt(DIR_CW, 8'h00, 16'h0d01));
        send_pkt(PORT_PE, mk_pkt(DIR_CCW, 8'h05, 16'h0d02));
        send_pkt(PORT_PE, mk_pkt(DIR_CW, 8'hff, 16'h0d03));
        repeat (20) @(posedge clk);
        #1;
        assert (rx_count == n0) else begin
            $display("%s: a packet with a bad hop code left the router", cur_test);
            errors++;
        end
        end_test();
    endtask

    task automatic transit_test();
        start_test("transit");
        send_pkt(PORT_CW, mk_pkt(DIR_CW, 8'h03, 16'h0a01));     // Stays on the ring
        send_pkt(PORT_CCW, mk_pkt(DIR_CCW, 8'h00, 16'h0b01));   // Exits to pe
        wait_drain();
        end_test();
    endtask

    task automatic backpressure_test();
        int low;
        int n;
        bit fell;
        start_test("back_pressure");
        low  = 0;
        fell = 1'b0;
        cw_ready_out = 1'b0;
        fork
            repeat (8) send_pkt(PORT_CW, mk_pkt(ring_dir_e'($urandom_range(1)),
                                                8'($urandom) | 8'h01, 16'h0a02));
            begin
                // Ready low in two phases in a row means both planes are full
                for (n = 0; n < WAIT_LIMIT / 2 && !fell; n++) begin
                    @(negedge clk);
                    low  = cw_ready_in ? 0 : low + 1;
                    fell = (low >= 2);
                end
                @(posedge clk);
                #1;
                cw_ready_out = 1'b1;
            end
        join
        assert (fell) else begin
            $display("%s: cw ready never fell while the cw output was stalled", cur_test);
            errors++;
        end
        wait_drain();
        end_test();
    endtask

    task automatic contention_test();
        start_test("contention");
        fork                                                  // Both aim at cw out
            repeat (12) send_pkt(PORT_CW, mk_pkt(DIR_CW, 8'h01, 16'h0a03));
            repeat (12) send_pkt(PORT_PE, mk_pkt(DIR_CW, 8'h01, 16'h0e05));
        join
        wait_drain();
        end_test();
    endtask

    initial begin
        void'($urandom(48658));
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_test();
        inject_test();
        drop_test();
        transit_test();
        backpressure_test();
        contention_test();
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (tests_failed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+design
design/ring_pkt_pkg.sv
design/ring_ctl_pkg.sv
design/slot_buffer.sv
design/inject_filter.sv
design/rr_arbiter.sv
design/vc_plane.sv
design/gold_router.sv
tests/gold_router_asserts.sv
tests/gold_router_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
TB_TOP     = gold_router_tb
RTL_TOP    = gold_router
FILELIST   = compile.f
BUILD_DIR  = obj_dir
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
